/* Bender.yml */
package:
  name: pc_glue

export_include_dirs:
  - .

sources:
  - pc_glue_pkg.sv
  - io_decode.sv
  - io_read_mux.sv
  - sysctl_port.sv
  - io_bus_ctrl.sv
  - pc_glue_top.sv
  - target: simulation
    files:
      - tb_pc_glue.sv

/* io_bus_ctrl.sv */
`include "pc_glue_cfg.svh"

module io_bus_ctrl (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  req_valid,
	output logic                  req_ready,
	input  pc_glue_pkg::io_req_t  req,
	output logic                  rsp_valid,
	input  logic                  rsp_ready,
	output pc_glue_pkg::io_rsp_t  rsp,
	output pc_glue_pkg::io_bus_t  bus,
	input  logic [`IO_DATA_W-1:0] rd_data
);
	import pc_glue_pkg::*;

	bus_state_e state;
	bus_state_e state_next;
	logic       is_write;

	assign req_ready = state == st_idle;
	assign rsp_valid = state == st_respond;

	always_comb begin
		state_next = state;
		case (state)
			st_idle:    if (req_valid) state_next = st_decode;
			st_decode:  state_next = st_access;
			st_access:  state_next = st_respond;
			st_respond: if (rsp_ready) state_next = st_idle;
			default:    state_next = st_idle;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (req_valid && req_ready) begin
			is_write      <= req.write;
			bus.size      <= req.size;
			bus.writedata <= req.data;
		end
		if (reset) begin
			state       <= st_idle;
			bus.address <= `IO_PARK_ADDR;
			bus.read    <= 1'b0;
			bus.write   <= 1'b0;
		end else begin
			state <= state_next;
			case (state)
				st_idle: begin
					if (req_valid)
						bus.address <= req.address;
				end
				st_decode: begin
					bus.read  <= !is_write; // Selects are settled from here on.
					bus.write <= is_write;
				end
				st_access: begin
					bus.read    <= 1'b0;
					bus.write   <= 1'b0;
					bus.address <= `IO_PARK_ADDR; // Selects drop before the next request.
				end
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (state == st_access)
			rsp.data <= is_write ? '0 : rd_data;
	end

	a_strobe_in_access: assert property (@(posedge clk_sys) disable iff (reset)
		(bus.read || bus.write) |-> state == st_access);

	a_rsp_hold: assert property (@(posedge clk_sys) disable iff (reset)
		rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp));

endmodule

/* io_decode.sv */
`include "pc_glue_cfg.svh"

module io_decode (
	input  logic                  clk_sys,
	input  logic [`IO_ADDR_W-1:0] addr,
	output pc_glue_pkg::io_sel_t  sel,
	output logic                  sysctl_sel
);

	function automatic logic hit(
		input logic [`IO_ADDR_W-1:0] a,
		input logic [`IO_ADDR_W-1:0] base,
		input int unsigned           bits
	);
		return (a >> bits) == (base >> bits);
	endfunction

	always_ff @(posedge clk_sys) begin
		sel.ide0       <= hit(addr, `IDE0_BASE, `IDE0_BITS) ||
		                  hit(addr, `IDE0_ALT_BASE, `IDE0_ALT_BITS);
		sel.ide1       <= hit(addr, `IDE1_BASE, `IDE1_BITS) ||
		                  hit(addr, `IDE1_ALT_BASE, `IDE1_ALT_BITS);
		sel.floppy     <= hit(addr, `FDC_BASE, `FDC_BITS) ||
		                  hit(addr, `FDC_B_BASE, `FDC_B_BITS) ||
		                  hit(addr, `FDC_C_BASE, `FDC_C_BITS);
		sel.dma_master <= hit(addr, `DMA_MASTER_BASE, `DMA_MASTER_BITS);
		sel.dma_slave  <= hit(addr, `DMA_SLAVE_BASE, `DMA_SLAVE_BITS);
		sel.dma_page   <= hit(addr, `DMA_PAGE_BASE, `DMA_PAGE_BITS);
		sel.pic_master <= hit(addr, `PIC_MASTER_BASE, `PIC_MASTER_BITS);
		sel.pic_slave  <= hit(addr, `PIC_SLAVE_BASE, `PIC_SLAVE_BITS);
		sel.pit        <= hit(addr, `PIT_BASE, `PIT_BITS) ||
		                  hit(addr, `PIT_SPK_BASE, `PIT_SPK_BITS);
		// Port 0x61 sits inside the keyboard window but belongs to the timer.
		sel.ps2_io     <= hit(addr, `PS2_IO_BASE, `PS2_IO_BITS) &&
		                  !hit(addr, `PIT_SPK_BASE, `PIT_SPK_BITS);
		sel.ps2_ctl    <= hit(addr, `PS2_CTL_BASE, `PS2_CTL_BITS);
		sel.rtc        <= hit(addr, `RTC_BASE, `RTC_BITS);
		sel.fm         <= hit(addr, `FM_BASE, `FM_BITS);
		sel.sb         <= hit(addr, `SB_BASE, `SB_BITS);
		sel.uart1      <= hit(addr, `UART1_BASE, `UART1_BITS);
		sel.uart2      <= hit(addr, `UART2_BASE, `UART2_BITS);
		sel.mpu        <= hit(addr, `MPU_BASE, `MPU_BITS);
		sel.vga_b      <= hit(addr, `VGA_B_BASE, `VGA_B_BITS);
		sel.vga_c      <= hit(addr, `VGA_C_BASE, `VGA_C_BITS);
		sel.vga_d      <= hit(addr, `VGA_D_BASE, `VGA_D_BITS);
		sel.joy        <= hit(addr, `JOY_BASE, `JOY_BITS);
		sysctl_sel     <= addr == `SYSCTL_PORT;
	end

	// The device windows must never overlap.
	a_one_select: assert property (@(posedge clk_sys)
		!$isunknown({sel, sysctl_sel}) |-> $onehot0({sel, sysctl_sel}));

endmodule

/* io_read_mux.sv */
`include "pc_glue_cfg.svh"

module io_read_mux (
	input  pc_glue_pkg::io_sel_t   sel,
	input  pc_glue_pkg::io_rdata_t rdata,
	output logic [`IO_DATA_W-1:0]  data
);

	logic [7:0] byte_data;

	always_comb begin
		byte_data = 8'hFF; // Open bus.
		if (sel.floppy)
			byte_data = rdata.floppy;
		else if (sel.dma_master || sel.dma_slave || sel.dma_page)
			byte_data = rdata.dma;
		else if (sel.pic_master || sel.pic_slave)
			byte_data = rdata.pic;
		else if (sel.pit)
			byte_data = rdata.pit;
		else if (sel.ps2_io || sel.ps2_ctl)
			byte_data = rdata.ps2;
		else if (sel.rtc)
			byte_data = rdata.rtc;
		else if (sel.sb || sel.fm)
			byte_data = rdata.sound;
		else if (sel.uart1)
			byte_data = rdata.uart1;
		else if (sel.uart2)
			byte_data = rdata.uart2;
		else if (sel.mpu)
			byte_data = rdata.mpu;
		else if (sel.vga_b || sel.vga_c || sel.vga_d)
			byte_data = rdata.vga;
		else if (sel.joy)
			byte_data = rdata.joy;
	end

	// Disk ports carry full 32-bit words and win over the byte devices.
	assign data = sel.ide0 ? rdata.ide0 :
	              sel.ide1 ? rdata.ide1 :
	              {{(`IO_DATA_W-8){1'b0}}, byte_data};

endmodule

/* pc_glue_cfg.svh */
`ifndef PC_GLUE_CFG_SVH
`define PC_GLUE_CFG_SVH

`define IO_ADDR_W 16
`define IO_DATA_W 32

`define SYSCTL_RESET_VAL 8'hA2
`define SYSCTL_KEY 8'hA1
`define SYSCTL_PORT 16'h8888

// Address driven onto the bus between transfers. No window contains it.
`define IO_PARK_ADDR 16'hFFFF

`define IDE0_BASE 16'h01F0
`define IDE0_BITS 3
`define IDE0_ALT_BASE 16'h03F6
`define IDE0_ALT_BITS 0
`define IDE1_BASE 16'h0170
`define IDE1_BITS 3
`define IDE1_ALT_BASE 16'h0376
`define IDE1_ALT_BITS 0
`define FDC_BASE 16'h03F0
`define FDC_BITS 2
`define FDC_B_BASE 16'h03F4
`define FDC_B_BITS 1
`define FDC_C_BASE 16'h03F7
`define FDC_C_BITS 0
`define DMA_MASTER_BASE 16'h00C0
`define DMA_MASTER_BITS 5
`define DMA_PAGE_BASE 16'h0080
`define DMA_PAGE_BITS 4
`define DMA_SLAVE_BASE 16'h0000
`define DMA_SLAVE_BITS 4
`define PIC_MASTER_BASE 16'h0020
`define PIC_MASTER_BITS 1
`define PIC_SLAVE_BASE 16'h00A0
`define PIC_SLAVE_BITS 1
`define PIT_BASE 16'h0040
`define PIT_BITS 2
`define PIT_SPK_BASE 16'h0061
`define PIT_SPK_BITS 0
`define PS2_IO_BASE 16'h0060
`define PS2_IO_BITS 3
`define PS2_CTL_BASE 16'h0090
`define PS2_CTL_BITS 4
`define RTC_BASE 16'h0070
`define RTC_BITS 1
`define FM_BASE 16'h0388
`define FM_BITS 2
`define SB_BASE 16'h0220
`define SB_BITS 4
`define UART1_BASE 16'h03F8
`define UART1_BITS 3
`define UART2_BASE 16'h02F8
`define UART2_BITS 3
`define MPU_BASE 16'h0330
`define MPU_BITS 1
`define VGA_B_BASE 16'h03B0
`define VGA_B_BITS 4
`define VGA_C_BASE 16'h03C0
`define VGA_C_BITS 4
`define VGA_D_BASE 16'h03D0
`define VGA_D_BITS 4
`define JOY_BASE 16'h0201
`define JOY_BITS 0

`endif

/* pc_glue_pkg.sv */
`include "pc_glue_cfg.svh"

package pc_glue_pkg;

	typedef enum logic [1:0] {
		size_byte  = 2'd0,
		size_word  = 2'd1,
		size_dword = 2'd2
	} io_size_e;

	typedef enum logic [1:0] {
		st_idle,
		st_decode,
		st_access,
		st_respond
	} bus_state_e;

	typedef struct packed {
		logic                  write;
		logic [`IO_ADDR_W-1:0] address;
		io_size_e              size;
		logic [`IO_DATA_W-1:0] data;
	} io_req_t;

	typedef struct packed {
		logic [`IO_DATA_W-1:0] data; // Zero for a write.
	} io_rsp_t;

	typedef struct packed {
		logic [`IO_ADDR_W-1:0] address;
		logic                  read;
		logic                  write;
		io_size_e              size;
		logic [`IO_DATA_W-1:0] writedata;
	} io_bus_t;

	typedef struct packed {
		logic ide0;
		logic ide1;
		logic floppy;
		logic dma_master;
		logic dma_slave;
		logic dma_page;
		logic pic_master;
		logic pic_slave;
		logic pit;
		logic ps2_io;
		logic ps2_ctl;
		logic rtc;
		logic fm;
		logic sb;
		logic uart1;
		logic uart2;
		logic mpu;
		logic vga_b;
		logic vga_c;
		logic vga_d;
		logic joy;
	} io_sel_t;

	typedef struct packed {
		logic [`IO_DATA_W-1:0] ide0;
		logic [`IO_DATA_W-1:0] ide1;
		logic [7:0]            floppy;
		logic [7:0]            dma;
		logic [7:0]            pic;
		logic [7:0]            pit;
		logic [7:0]            ps2;
		logic [7:0]            rtc;
		logic [7:0]            sound;
		logic [7:0]            uart1;
		logic [7:0]            uart2;
		logic [7:0]            mpu;
		logic [7:0]            vga;
		logic [7:0]            joy;
	} io_rdata_t;

	typedef struct packed {
		logic timer;
		logic keyboard;
		logic vga;
		logic uart2;
		logic uart1;
		logic sb5;
		logic floppy;
		logic sb7;
		logic rtc;
		logic mpu;
		logic sb10;
		logic mouse;
		logic ide0;
		logic ide1;
	} dev_irq_t;

endpackage

/* pc_glue_top.sv */
`include "pc_glue_cfg.svh"

module pc_glue_top (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   req_valid,
	output logic                   req_ready,
	input  pc_glue_pkg::io_req_t   req,
	output logic                   rsp_valid,
	input  logic                   rsp_ready,
	output pc_glue_pkg::io_rsp_t   rsp,
	output pc_glue_pkg::io_bus_t   dev_bus,
	output pc_glue_pkg::io_sel_t   dev_sel,
	input  pc_glue_pkg::io_rdata_t dev_rdata,
	input  pc_glue_pkg::dev_irq_t  dev_irq,
	output logic [15:0]            pic_irq,
	output logic [7:0]             syscfg
);

	logic                  sysctl_sel;
	logic [`IO_DATA_W-1:0] rd_data;

	io_bus_ctrl u_bus_ctrl (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.req_valid (req_valid),
		.req_ready (req_ready),
		.req       (req),
		.rsp_valid (rsp_valid),
		.rsp_ready (rsp_ready),
		.rsp       (rsp),
		.bus       (dev_bus),
		.rd_data   (rd_data)
	);

	io_decode u_decode (
		.clk_sys    (clk_sys),
		.addr       (dev_bus.address),
		.sel        (dev_sel),
		.sysctl_sel (sysctl_sel)
	);

	io_read_mux u_read_mux (
		.sel   (dev_sel),
		.rdata (dev_rdata),
		.data  (rd_data)
	);

	sysctl_port u_sysctl (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.bus        (dev_bus),
		.sel        (dev_sel),
		.sysctl_sel (sysctl_sel),
		.syscfg     (syscfg)
	);

	always_comb begin
		pic_irq     = '0;
		pic_irq[0]  = dev_irq.timer;
		pic_irq[1]  = dev_irq.keyboard;
		pic_irq[3]  = dev_irq.uart2;
		pic_irq[4]  = dev_irq.uart1;
		pic_irq[5]  = dev_irq.sb5;
		pic_irq[6]  = dev_irq.floppy;
		pic_irq[7]  = dev_irq.sb7;
		pic_irq[8]  = dev_irq.rtc;
		pic_irq[9]  = dev_irq.mpu || dev_irq.vga; // Line 2 is the cascade, so VGA lands on 9.
		pic_irq[10] = dev_irq.sb10;
		pic_irq[12] = dev_irq.mouse;
		pic_irq[14] = dev_irq.ide0;
		pic_irq[15] = dev_irq.ide1;
	end

endmodule

/* sysctl_port.sv */
`include "pc_glue_cfg.svh"

module sysctl_port (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  pc_glue_pkg::io_bus_t bus,
	input  pc_glue_pkg::io_sel_t sel,
	input  logic                 sysctl_sel,
	output logic [7:0]           syscfg
);
	import pc_glue_pkg::*;

	logic in_reset;
	logic disk_hit;
	logic key_write;

	assign disk_hit  = sel.ide0 || sel.ide1 || sel.floppy;
	assign key_write = bus.write && sysctl_sel && bus.size == size_word &&
	                   bus.writedata[15:8] == `SYSCTL_KEY;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			syscfg   <= `SYSCTL_RESET_VAL;
			in_reset <= 1'b1;
		end else if (disk_hit && in_reset) begin
			syscfg   <= 8'h00; // The first disk access ends the boot setup.
			in_reset <= 1'b0;
		end else if (key_write) begin
			syscfg   <= bus.writedata[7:0];
			in_reset <= 1'b0;
		end
	end

endmodule

/* tb_pc_glue.sv */
module tb_pc_glue;
	timeunit 1ns;
	timeprecision 1ps;
	import pc_glue_pkg::*;

	localparam int n_win = 26;
	localparam int n_stall_tx = 32;
	localparam int stall_max = 6;
	localparam int n_tx = 1 + n_win + 2 + 4 + n_stall_tx;
	localparam int watchdog_cycles = n_tx * 6 + n_stall_tx * stall_max + 200;
	localparam logic [31:0] ide0_word = 32'hC0DE_01F0;
	localparam logic [31:0] ide1_word = 32'h5A17_0170;

	// One port per window, with the device model value it must return.
	localparam logic [15:0] win_addr [n_win] = '{
		16'h01F0, 16'h03F6, 16'h0170, 16'h0376, 16'h03F2, 16'h03F5, 16'h03F7,
		16'h00C4, 16'h0003, 16'h0081, 16'h0020, 16'h00A1, 16'h0040, 16'h0061,
		16'h0060, 16'h0092, 16'h0071, 16'h0388, 16'h022C, 16'h03F8, 16'h02F8,
		16'h0331, 16'h03B4, 16'h03C5, 16'h03DA, 16'h0201
	};
	localparam logic [31:0] win_exp [n_win] = '{
		ide0_word, ide0_word, ide1_word, ide1_word, 32'h11, 32'h11, 32'h11,
		32'h12, 32'h12, 32'h12, 32'h13, 32'h13, 32'h14, 32'h14,
		32'h15, 32'h15, 32'h16, 32'h17, 32'h17, 32'h18, 32'h19,
		32'h1A, 32'h1B, 32'h1B, 32'h1B, 32'h1C
	};
	// PIC line of each interrupt source, in dev_irq_t field order.
	localparam int irq_line [14] = '{0, 1, 9, 3, 4, 5, 6, 7, 8, 9, 10, 12, 14, 15};

	logic        clk_sys;
	logic        reset;
	logic        req_valid;
	logic        req_ready;
	io_req_t     req;
	logic        rsp_valid;
	logic        rsp_ready;
	io_rsp_t     rsp;
	io_bus_t     dev_bus;
	io_sel_t     dev_sel;
	io_rdata_t   dev_rdata;
	dev_irq_t    dev_irq;
	logic [15:0] pic_irq;
	logic [7:0]  syscfg;
	logic        unmapped_active;
	logic [31:0] rdata;
	int          pass_count;
	int          fail_count;
	int          test_errors;
	int          idx;
	logic        wr;

	pc_glue_top dut_i (.*);

	assign dev_rdata = '{ide0: ide0_word, ide1: ide1_word, floppy: 8'h11, dma: 8'h12,
	                     pic: 8'h13, pit: 8'h14, ps2: 8'h15, rtc: 8'h16, sound: 8'h17,
	                     uart1: 8'h18, uart2: 8'h19, mpu: 8'h1A, vga: 8'h1B, joy: 8'h1C};

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	initial begin
		#(watchdog_cycles * 4);
		$display("Timeout: the transfers stopped completing");
		$display("Test failed");
		$finish;
	end

	task automatic note_error(input string what);
		fail_count++;
		test_errors++;
		$display("%s", what);
	endtask

	task automatic check_value(input string name, input logic [31:0] exp,
	                           input logic [31:0] act);
		assert (act === exp) pass_count++;
		else note_error($sformatf("Fail %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic finish_test(input string name);
		if (test_errors == 0)
			$display("%s: ok", name);
		else
			$display("%s: %0d errors", name, test_errors);
		test_errors = 0;
	endtask

	// One CPU transfer. rsp_ready is held low for up to stalls cycles at random.
	task automatic run_io(input logic write, input logic [15:0] addr, input io_size_e size,
	                      input logic [31:0] data, input int stalls, output logic [31:0] result);
		int   waited;
		logic taken;
		@(negedge clk_sys);
		req_valid = 1'b1;
		req = '{write: write, address: addr, size: size, data: data};
		while (!req_ready) @(negedge clk_sys);
		@(negedge clk_sys); // Accepted on the edge just passed.
		req_valid = 1'b0;
		waited = 0;
		taken = 1'b0;
		while (!taken) begin
			rsp_ready = (waited >= stalls) || ($urandom_range(2) == 0);
			taken = rsp_valid && rsp_ready;
			result = rsp.data;
			if (rsp_valid) waited++;
			@(negedge clk_sys);
		end
		rsp_ready = 1'b0;
	endtask

	a_latency: assert property (@(posedge clk_sys) disable iff (reset)
		req_valid && req_ready |-> !rsp_valid [*3] ##1 rsp_valid)
		else note_error("The response did not arrive exactly 3 cycles after acceptance");

	a_rsp_stable: assert property (@(posedge clk_sys) disable iff (reset)
		rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
		else note_error("The response changed while it was stalled");

	a_busy: assert property (@(posedge clk_sys) disable iff (reset)
		(req_valid && req_ready |=> !req_ready [*3]) and (rsp_valid |-> !req_ready))
		else note_error("A new request was accepted while a transfer was in flight");

	// Address first, then one strobe cycle that carries the accepted request.
	a_bus_cycle: assert property (@(posedge clk_sys) disable iff (reset)
		req_valid && req_ready |=>
		dev_bus.address == $past(req.address) && !dev_bus.read && !dev_bus.write
		##1 dev_bus.read == !$past(req.write, 2) && dev_bus.write == $past(req.write, 2) &&
		dev_bus.address == $past(req.address, 2) && dev_bus.size == $past(req.size, 2) &&
		dev_bus.writedata == $past(req.data, 2)
		##1 !dev_bus.read && !dev_bus.write)
		else note_error("The device bus cycle did not match the accepted request");

	a_no_select: assert property (@(posedge clk_sys)
		unmapped_active |-> dev_sel == '0)
		else note_error("A device select rose during an unmapped transfer");

	initial begin
		void'($urandom(32'h9906));
		reset = 1'b1;
		req_valid = 1'b0;
		req = '0;
		rsp_ready = 1'b0;
		dev_irq = '0;
		unmapped_active = 1'b0;
		pass_count = 0;
		fail_count = 0;
		test_errors = 0;
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;

		check_value("syscfg after reset", 32'hA2, {24'h0, syscfg});
		run_io(1'b0, 16'h01F0, size_dword, '0, 0, rdata);
		check_value("syscfg after disk read", 32'h00, {24'h0, syscfg});
		finish_test("syscfg auto clear");

		for (int i = 0; i < n_win; i++) begin
			run_io(1'b0, win_addr[i], size_byte, '0, 0, rdata);
			check_value($sformatf("read %h", win_addr[i]), win_exp[i], rdata);
		end
		check_value("syscfg after more disk reads", 32'h00, {24'h0, syscfg});
		finish_test("window reads");

		unmapped_active = 1'b1;
		run_io(1'b0, 16'h0300, size_byte, '0, 0, rdata);
		check_value("read 0300", 32'h0000_00FF, rdata);
		run_io(1'b0, 16'h0400, size_dword, '0, 0, rdata);
		check_value("read 0400", 32'h0000_00FF, rdata);
		unmapped_active = 1'b0;
		finish_test("unmapped reads");

		run_io(1'b1, `SYSCTL_PORT, size_word, 32'h0000_A15C, 0, rdata);
		check_value("syscfg key write", 32'h5C, {24'h0, syscfg});
		run_io(1'b1, `SYSCTL_PORT, size_word, 32'h0000_B233, 0, rdata);
		check_value("syscfg wrong key", 32'h5C, {24'h0, syscfg});
		run_io(1'b1, `SYSCTL_PORT, size_byte, 32'h0000_A177, 0, rdata);
		check_value("syscfg byte write", 32'h5C, {24'h0, syscfg});
		run_io(1'b0, 16'h0170, size_dword, '0, 0, rdata);
		check_value("syscfg after key and disk", 32'h5C, {24'h0, syscfg});
		finish_test("syscfg unlock");

		for (int i = 0; i < n_stall_tx; i++) begin
			idx = $urandom_range(n_win - 1);
			wr = $urandom_range(1);
			run_io(wr, win_addr[idx], size_dword, $urandom, stall_max, rdata);
			check_value($sformatf("stalled %s %h", wr ? "write" : "read", win_addr[idx]),
			            wr ? 32'h0 : win_exp[idx], rdata);
		end
		finish_test("response stalls");

		for (int i = 0; i < 14; i++) begin
			@(negedge clk_sys);
			dev_irq = dev_irq_t'(14'b1 << (13 - i));
			#1;
			check_value($sformatf("irq source %0d", i), 32'(16'b1 << irq_line[i]),
			            {16'h0, pic_irq});
		end
		dev_irq = '0;
		#1;
		check_value("irq idle", 32'h0, {16'h0, pic_irq});
		finish_test("interrupt routing");

		$display("Checks passed: %0d, checks failed: %0d", pass_count, fail_count);
		if (fail_count == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

/* verilog.f */
+incdir+.
pc_glue_pkg.sv
io_decode.sv
io_read_mux.sv
sysctl_port.sv
io_bus_ctrl.sv
pc_glue_top.sv
tb_pc_glue.sv
